// File: hw/uart_pkg.sv
package uart_pkg;

    // Level of an idle serial line, also the stop bit level
    localparam logic LINE_IDLE = 1'b1;

    // Receiver FSM
    typedef enum logic [2:0] {
        RX_IDLE,
        RX_START,    // Waiting for the middle of the start bit
        RX_DATA,
        RX_STOP,
        RX_CLEANUP   // Byte held here until the consumer takes it
    } rx_state_t;

    // Transmitter FSM
    typedef enum logic [1:0] {
        TX_IDLE,
        TX_START,
        TX_DATA,
        TX_STOP
    } tx_state_t;

endpackage : uart_pkg

// File: hw/bridge_pkg.sv
package bridge_pkg;

    // Size of the register file
    localparam int NUM_REGS = 4;
    localparam int ADDR_W   = $clog2(NUM_REGS);  // 2 bits

    // First byte of every command
    typedef enum logic [7:0] {
        OP_WRITE = 8'h57,  // 'W'
        OP_READ  = 8'h52   // 'R'
    } opcode_t;

    // Reply bytes
    localparam logic [7:0] RSP_ACK = 8'hAA;
    localparam logic [7:0] RSP_ERR = 8'hEE;

    // Command parser FSM
    typedef enum logic [1:0] {
        WAIT_OP,
        WAIT_ADDR,
        WAIT_DATA,
        RESPOND
    } parse_state_t;

endpackage : bridge_pkg

// File: hw/uart_rx.sv
`timescale 1ns/1ps

module uart_rx #(
    parameter int CLKS_PER_BIT = 868
)(
    input  logic       i_clk,
    input  logic       i_rst_n,
    input  logic       i_rx,
    input  logic       i_rx_ready,
    output logic [7:0] o_rx_data,
    output logic       o_rx_valid
);

    localparam int CNT_W = $clog2(CLKS_PER_BIT);

    uart_pkg::rx_state_t r_state, w_next_state;
    logic [CNT_W-1:0] r_clk_count, w_clk_count_next;
    logic [2:0]       r_bit_index, w_bit_index_next;
    logic [7:0]       r_data;
    logic             r_valid;
    logic             r_sync1, r_sync2;
    logic             w_sample;  // Data bit center reached

    // Two flop synchronizer for the asynchronous line
    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            r_sync1 <= uart_pkg::LINE_IDLE;
            r_sync2 <= uart_pkg::LINE_IDLE;
        end else begin
            r_sync1 <= i_rx;
            r_sync2 <= r_sync1;
        end
    end

    always_comb begin
        w_next_state     = r_state;
        w_clk_count_next = r_clk_count + 1'b1;
        w_bit_index_next = r_bit_index;
        w_sample         = 1'b0;
        case (r_state)
            uart_pkg::RX_IDLE: begin
                w_clk_count_next = '0;
                w_bit_index_next = '0;
                if (r_sync2 == 1'b0) w_next_state = uart_pkg::RX_START;
            end
            uart_pkg::RX_START: begin
                if (r_clk_count == CNT_W'((CLKS_PER_BIT - 1) / 2)) begin
                    w_clk_count_next = '0;
                    // Line back high at mid-bit means a glitch
                    w_next_state = (r_sync2 == 1'b0) ? uart_pkg::RX_DATA : uart_pkg::RX_IDLE;
                end
            end
            uart_pkg::RX_DATA: begin
                if (r_clk_count == CNT_W'(CLKS_PER_BIT - 1)) begin
                    w_clk_count_next = '0;
                    w_sample         = 1'b1;
                    if (r_bit_index == 3'd7) begin
                        w_next_state = uart_pkg::RX_STOP;
                    end else begin
                        w_bit_index_next = r_bit_index + 1'b1;
                    end
                end
            end
            uart_pkg::RX_STOP: begin
                if (r_clk_count == CNT_W'(CLKS_PER_BIT - 1)) begin  // Stop bit center
                    w_clk_count_next = '0;
                    w_next_state     = uart_pkg::RX_CLEANUP;
                end
            end
            uart_pkg::RX_CLEANUP: begin
                w_clk_count_next = '0;
                if (i_rx_ready) w_next_state = uart_pkg::RX_IDLE;  // Line ignored until taken
            end
            default: w_next_state = uart_pkg::RX_IDLE;
        endcase
    end

    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            r_state     <= uart_pkg::RX_IDLE;
            r_clk_count <= '0;
            r_bit_index <= '0;
            r_valid     <= 1'b0;
        end else begin
            r_state     <= w_next_state;
            r_clk_count <= w_clk_count_next;
            r_bit_index <= w_bit_index_next;
            r_valid     <= (w_next_state == uart_pkg::RX_CLEANUP);
        end
    end

    // LSB arrives first, shifted in from the top
    always_ff @(posedge i_clk) begin
        if (w_sample) r_data <= {r_sync2, r_data[7:1]};
    end

    assign o_rx_data  = r_data;
    assign o_rx_valid = r_valid;

    // Stalled byte must be held until the consumer takes it
    a_rx_hold: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        (o_rx_valid && !i_rx_ready) |=> (o_rx_valid && $stable(o_rx_data)));

endmodule : uart_rx

// File: hw/uart_tx.sv
`timescale 1ns/1ps

module uart_tx #(
    parameter int CLKS_PER_BIT = 868
)(
    input  logic       i_clk,
    input  logic       i_rst_n,
    input  logic [7:0] i_tx_data,
    input  logic       i_tx_valid,
    output logic       o_tx_ready,
    output logic       o_tx
);

    localparam int CNT_W = $clog2(CLKS_PER_BIT);

    uart_pkg::tx_state_t r_state;
    logic [CNT_W-1:0] r_clk_count;
    logic [2:0]       r_bit_index;
    logic [7:0]       r_shift;
    logic             r_tx;
    logic             w_accept;
    logic             w_bit_end;

    assign o_tx_ready = (r_state == uart_pkg::TX_IDLE);
    assign w_accept   = i_tx_valid && o_tx_ready;
    assign w_bit_end  = (r_clk_count == CNT_W'(CLKS_PER_BIT - 1));

    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            r_state     <= uart_pkg::TX_IDLE;
            r_clk_count <= '0;
            r_bit_index <= '0;
            r_tx        <= uart_pkg::LINE_IDLE;
        end else begin
            r_clk_count <= w_bit_end ? '0 : r_clk_count + 1'b1;
            case (r_state)
                uart_pkg::TX_IDLE: begin
                    r_clk_count <= '0;
                    r_bit_index <= '0;
                    r_tx        <= uart_pkg::LINE_IDLE;
                    if (w_accept) begin
                        r_tx    <= 1'b0;  // Start bit
                        r_state <= uart_pkg::TX_START;
                    end
                end
                uart_pkg::TX_START: begin
                    if (w_bit_end) begin
                        r_tx    <= r_shift[0];
                        r_state <= uart_pkg::TX_DATA;
                    end
                end
                uart_pkg::TX_DATA: begin
                    if (w_bit_end) begin
                        if (r_bit_index == 3'd7) begin
                            r_tx    <= uart_pkg::LINE_IDLE;  // Stop bit
                            r_state <= uart_pkg::TX_STOP;
                        end else begin
                            r_tx        <= r_shift[1];  // Next bit before the shift lands
                            r_bit_index <= r_bit_index + 1'b1;
                        end
                    end
                end
                uart_pkg::TX_STOP: begin
                    if (w_bit_end) r_state <= uart_pkg::TX_IDLE;
                end
                default: r_state <= uart_pkg::TX_IDLE;
            endcase
        end
    end

    always_ff @(posedge i_clk) begin
        if (w_accept) begin
            r_shift <= i_tx_data;
        end else if (r_state == uart_pkg::TX_DATA && w_bit_end) begin
            r_shift <= {1'b0, r_shift[7:1]};
        end
    end

    assign o_tx = r_tx;

    // Line must rest high between frames
    a_tx_idle_high: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        (r_state == uart_pkg::TX_IDLE) |-> o_tx);

endmodule : uart_tx

// File: hw/reg_bridge.sv
`timescale 1ns/1ps

module reg_bridge (
    input  logic       i_clk,
    input  logic       i_rst_n,
    input  logic [7:0] i_rx_data,
    input  logic       i_rx_valid,
    input  logic       i_tx_ready,
    output logic       o_rx_ready,
    output logic [7:0] o_tx_data,
    output logic       o_tx_valid
);

    bridge_pkg::parse_state_t r_state, w_next_state;
    bridge_pkg::opcode_t      r_opcode;
    logic [7:0] r_regs [bridge_pkg::NUM_REGS];
    logic [7:0] r_addr;
    logic [7:0] r_rsp, w_rsp;
    logic       r_tx_valid;
    logic       w_rx_fire;
    logic       w_tx_fire;
    logic       w_wr_en;
    logic       w_rx_addr_ok;   // Address byte on the input is in range
    logic       w_addr_ok;      // Latched address is in range

    assign o_rx_ready   = (r_state != bridge_pkg::RESPOND);
    assign w_rx_fire    = i_rx_valid && o_rx_ready;
    assign w_tx_fire    = r_tx_valid && i_tx_ready;
    assign w_rx_addr_ok = (i_rx_data < 8'(bridge_pkg::NUM_REGS));
    assign w_addr_ok    = (r_addr < 8'(bridge_pkg::NUM_REGS));

    always_comb begin
        w_next_state = r_state;
        w_rsp        = r_rsp;
        w_wr_en      = 1'b0;
        case (r_state)
            bridge_pkg::WAIT_OP: begin
                if (w_rx_fire) begin
                    case (i_rx_data)
                        bridge_pkg::OP_WRITE,
                        bridge_pkg::OP_READ: w_next_state = bridge_pkg::WAIT_ADDR;
                        default: begin
                            // Unknown opcode is answered at once
                            w_rsp        = bridge_pkg::RSP_ERR;
                            w_next_state = bridge_pkg::RESPOND;
                        end
                    endcase
                end
            end
            bridge_pkg::WAIT_ADDR: begin
                if (w_rx_fire) begin
                    if (r_opcode == bridge_pkg::OP_READ) begin
                        w_next_state = bridge_pkg::RESPOND;
                        w_rsp        = w_rx_addr_ok ? r_regs[i_rx_data[bridge_pkg::ADDR_W-1:0]]
                                                    : bridge_pkg::RSP_ERR;
                    end else begin
                        w_next_state = bridge_pkg::WAIT_DATA;
                    end
                end
            end
            bridge_pkg::WAIT_DATA: begin
                if (w_rx_fire) begin
                    w_next_state = bridge_pkg::RESPOND;
                    w_wr_en      = w_addr_ok;  // Out of range write is dropped
                    w_rsp        = w_addr_ok ? bridge_pkg::RSP_ACK : bridge_pkg::RSP_ERR;
                end
            end
            bridge_pkg::RESPOND: begin
                if (w_tx_fire) w_next_state = bridge_pkg::WAIT_OP;
            end
            default: w_next_state = bridge_pkg::WAIT_OP;
        endcase
    end

    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            r_state    <= bridge_pkg::WAIT_OP;
            r_tx_valid <= 1'b0;
            for (int i = 0; i < bridge_pkg::NUM_REGS; i++) begin
                r_regs[i] <= '0;
            end
        end else begin
            r_state    <= w_next_state;
            r_tx_valid <= (w_next_state == bridge_pkg::RESPOND);  // Offered the cycle after
            if (w_wr_en) r_regs[r_addr[bridge_pkg::ADDR_W-1:0]] <= i_rx_data;
        end
    end

    // Command fields and reply byte
    always_ff @(posedge i_clk) begin
        if (r_state == bridge_pkg::WAIT_OP && w_rx_fire) begin
            r_opcode <= bridge_pkg::opcode_t'(i_rx_data);
        end
        if (r_state == bridge_pkg::WAIT_ADDR && w_rx_fire) begin
            r_addr <= i_rx_data;
        end
        r_rsp <= w_rsp;
    end

    assign o_tx_data  = r_rsp;
    assign o_tx_valid = r_tx_valid;

    // Offered reply held until the transmitter takes it
    a_tx_hold: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        (o_tx_valid && !i_tx_ready) |=> (o_tx_valid && $stable(o_tx_data)));

endmodule : reg_bridge

// File: hw/uart_bridge_top.sv
`timescale 1ns/1ps

module uart_bridge_top #(
    parameter int CLKS_PER_BIT = 868  // 100 MHz at 115200 baud
)(
    input  logic i_clk,
    input  logic i_rst_n,
    input  logic i_rx,
    output logic o_tx
);

    logic [7:0] rx_data;
    logic       rx_valid;
    logic       rx_ready;
    logic [7:0] tx_data;
    logic       tx_valid;
    logic       tx_ready;

    uart_rx #(
        .CLKS_PER_BIT (CLKS_PER_BIT)
    ) u_uart_rx (
        .i_clk      (i_clk),
        .i_rst_n    (i_rst_n),
        .i_rx       (i_rx),
        .i_rx_ready (rx_ready),
        .o_rx_data  (rx_data),
        .o_rx_valid (rx_valid)
    );

    reg_bridge u_reg_bridge (
        .i_clk      (i_clk),
        .i_rst_n    (i_rst_n),
        .i_rx_data  (rx_data),
        .i_rx_valid (rx_valid),
        .i_tx_ready (tx_ready),
        .o_rx_ready (rx_ready),
        .o_tx_data  (tx_data),
        .o_tx_valid (tx_valid)
    );

    uart_tx #(
        .CLKS_PER_BIT (CLKS_PER_BIT)
    ) u_uart_tx (
        .i_clk      (i_clk),
        .i_rst_n    (i_rst_n),
        .i_tx_data  (tx_data),
        .i_tx_valid (tx_valid),
        .o_tx_ready (tx_ready),
        .o_tx       (o_tx)
    );

endmodule : uart_bridge_top

// File: bench/tb_uart_bridge.sv
`timescale 1ns/1ps

module tb_uart_bridge;

    localparam int CLKS_PER_BIT = 16;
    localparam int CLK_PERIOD   = 20;
    localparam int DRIVE_DLY    = 2;   // ns after the rising edge
    localparam int IDLE_BITS    = 20;  // Quiet time checked after reset

    logic i_clk;
    logic i_rst_n;
    logic i_rx;
    logic o_tx;

    int          errors;
    int          num_cmds;
    bit          armed;
    int          len_q[$];
    logic [23:0] cmd_q[$];  // First command byte in the low bits
    logic [7:0]  exp_q[$];

    uart_bridge_top #(
        .CLKS_PER_BIT (CLKS_PER_BIT)
    ) u_uart_bridge_top (
        .i_clk   (i_clk),
        .i_rst_n (i_rst_n),
        .i_rx    (i_rx),
        .o_tx    (o_tx)
    );

    initial begin
        i_clk = 1'b0;
        forever #(CLK_PERIOD / 2) i_clk = ~i_clk;
    end

    // Leaves the caller just after a rising edge
    task automatic wait_cycles(input int n);
        repeat (n) @(posedge i_clk);
        #DRIVE_DLY;
    endtask

    task automatic send_bit(input logic b);
        i_rx = b;
        wait_cycles(CLKS_PER_BIT);
    endtask

    task automatic send_byte(input logic [7:0] b);
        int i;
        send_bit(1'b0);
        for (i = 0; i < 8; i++) send_bit(b[i]);  // LSB first
        send_bit(1'b1);
    endtask

    task automatic send_command(input int len, input logic [23:0] bytes);
        int j;
        for (j = 0; j < len; j++) send_byte(bytes[8*j +: 8]);
    endtask

    // Samples on falling clock edges, away from o_tx updates
    task automatic receive_byte(input int idx, output logic [7:0] b);
        int i;
        b = '0;
        @(negedge o_tx);
        repeat (CLKS_PER_BIT / 2) @(negedge i_clk);
        if (o_tx !== 1'b0) begin
            $display("Start bit of reply %0d did not stay low up to mid-bit", idx);
            errors++;
        end
        for (i = 0; i < 8; i++) begin
            repeat (CLKS_PER_BIT) @(negedge i_clk);
            b[i] = o_tx;
        end
        repeat (CLKS_PER_BIT) @(negedge i_clk);
        if (o_tx !== 1'b1) begin
            $display("Stop bit of reply %0d is not high", idx);
            errors++;
        end
    endtask

    task automatic load_stimulus();
        int         fd;
        int         n;
        string      line;
        logic [7:0] b0, b1, b2, rsp;
        fd = $fopen("bench/bridge_stimulus.txt", "r");
        if (fd == 0) begin
            $display("Cannot open the stimulus file bench/bridge_stimulus.txt");
            errors++;
        end else begin
            while ($fgets(line, fd) != 0) begin
                // Comment lines fail the scan and are skipped
                if ($sscanf(line, "%d %h %h %h %h", n, b0, b1, b2, rsp) == 5) begin
                    len_q.push_back(n);
                    cmd_q.push_back({b2, b1, b0});
                    exp_q.push_back(rsp);
                end
            end
            $fclose(fd);
        end
    endtask

    task automatic check_idle_line();
        int k;
        bit seen;
        seen = 1'b0;
        for (k = 0; k < IDLE_BITS * CLKS_PER_BIT; k++) begin
            @(negedge i_clk);
            if (o_tx !== 1'b1 && !seen) begin
                $display("Error: o_tx after reset expected 0x1 got 0x%h", o_tx);
                errors++;
                seen = 1'b1;
            end
        end
    endtask

    // Watchdog sized from the command count
    initial begin
        wait (armed);
        #((num_cmds + 2) * 40 * CLKS_PER_BIT * CLK_PERIOD);
        $display("Timeout, a reply frame did not arrive in time");
        $display("Run stopped with %0d errors plus the timeout", errors);
        $display("Test FAILED");
        $finish;
    end

    initial begin
        logic [7:0] got;
        int         gap;
        int         c;
        i_rst_n = 1'b0;
        i_rx    = 1'b1;  // Idle line
        errors  = 0;
        void'($urandom(34));
        load_stimulus();
        num_cmds = len_q.size();
        if (num_cmds == 0) begin
            $display("No commands were found in the stimulus file");
            errors++;
        end
        armed = 1'b1;
        repeat (4) @(posedge i_clk);
        #DRIVE_DLY;
        i_rst_n = 1'b1;
        check_idle_line();
        for (c = 0; c < num_cmds; c++) begin
            gap = $urandom % 4;  // 0 to 3 bit times
            wait_cycles(gap * CLKS_PER_BIT + 1);
            fork
                send_command(len_q[c], cmd_q[c]);
                receive_byte(c, got);
            join
            if (got !== exp_q[c]) begin
                $display("Error: o_tx reply to command %0d expected 0x%02h got 0x%02h",
                         c, exp_q[c], got);
                errors++;
            end
        end
        $display("Run finished with %0d errors over %0d commands", errors, num_cmds);
        if (errors == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule : tb_uart_bridge

// File: bench/bridge_stimulus.txt
# count byte0 byte1 byte2 reply
# count in decimal, bytes in hex, unused bytes are 00
2 52 03 00 00   # reg 3 before any write
3 57 00 5a aa
2 52 00 00 5a
3 57 01 c3 aa
2 52 01 00 c3
3 57 02 0f aa
2 52 02 00 0f
3 57 03 f0 aa
2 52 03 00 f0
1 41 00 00 ee   # unknown opcode
2 52 01 00 c3   # parser back in step
1 ff 00 00 ee
3 57 04 99 ee   # address out of range
2 52 04 00 ee
3 57 80 11 ee
2 52 00 00 5a   # registers untouched
2 52 01 00 c3
2 52 02 00 0f
2 52 03 00 f0

// File: tb.f
hw/uart_pkg.sv
hw/bridge_pkg.sv
hw/uart_rx.sv
hw/uart_tx.sv
hw/reg_bridge.sv
hw/uart_bridge_top.sv
bench/tb_uart_bridge.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       := tb_uart_bridge
FILELIST  := tb.f
OBJ_DIR   := obj_dir
LOG       := sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove build output and the log"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@grep -qx "Test OK" $(LOG) || (echo "Simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
